// File: source/bp_config.svh
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////
`define XLEN            32 // Width of pc and instruction
`define FETCH_WIDTH     5  // Slots per fetch bundle

////////////////////////////////////////////////////////////
// Predictor table
////////////////////////////////////////////////////////////
`define RESOLVE_PORTS   3  // Training ports from the back end
`define BHT_ENTRIES     32 // Two-bit counters in the table
`define BHT_INDEX_BITS  5  // log2 of BHT_ENTRIES
`define BHT_INDEX_LSB   2  // Index taken from pc[6:2]

`endif

// File: source/rv_isa_pkg.sv
`include "bp_config.svh"

package rv_isa_pkg;

	// Opcode field sits in the low bits of every 32-bit encoding
	localparam int unsigned OPCODE_LSB   = 0;
	localparam int unsigned OPCODE_WIDTH = 7;

	// RV32I base opcodes
	typedef enum logic [OPCODE_WIDTH-1:0] {
		op_load     = 7'b0000011,
		op_misc_mem = 7'b0001111, // FENCE
		op_op_imm   = 7'b0010011,
		op_auipc    = 7'b0010111,
		op_store    = 7'b0100011,
		op_op       = 7'b0110011,
		op_lui      = 7'b0110111,
		op_branch   = 7'b1100011, // BEQ, BNE, BLT and friends
		op_jalr     = 7'b1100111,
		op_jal      = 7'b1101111,
		op_system   = 7'b1110011  // ECALL, EBREAK, CSR
	} rv_opcode_e;

	// Pull the opcode out of a raw instruction word
	function automatic rv_opcode_e opcode_of(input logic [`XLEN-1:0] instr);
		return rv_opcode_e'(instr[OPCODE_LSB +: OPCODE_WIDTH]);
	endfunction

endpackage

// File: source/bp_types_pkg.sv
`include "bp_config.svh"

package bp_types_pkg;

	////////////////////////////////////////////////////////////
	// Predictor state
	////////////////////////////////////////////////////////////

	// Upper bit is the prediction
	typedef enum logic [1:0] {
		strong_not_taken = 2'b00,
		weak_not_taken   = 2'b01, // Reset value
		weak_taken       = 2'b10,
		strong_taken     = 2'b11
	} bp_counter_e;

	////////////////////////////////////////////////////////////
	// Fetch side
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] instr;
	} fetch_slot_t; // 64 bits

	typedef fetch_slot_t [`FETCH_WIDTH-1:0] fetch_bundle_t; // Slot 0 in the low bits

	typedef logic [`FETCH_WIDTH-1:0] slot_mask_t; // One bit per slot

	// Lookup request from decode into the table
	typedef struct packed {
		slot_mask_t                                    branch; // Slot holds a B-type
		logic [`FETCH_WIDTH-1:0][`BHT_INDEX_BITS-1:0] index;  // pc[6:2] per slot
	} bht_query_t; // 30 bits

	////////////////////////////////////////////////////////////
	// Resolution side
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic             valid;
		logic             mispredict; // Level, meaningful only with valid
		logic [`XLEN-1:0] pc;         // Pc of the resolved branch
	} resolve_t; // 34 bits

	typedef resolve_t [`RESOLVE_PORTS-1:0] resolve_bundle_t; // Port 0 applied first

endpackage

// File: source/branch_predictor.sv
`timescale 1ns/1ps
`include "bp_config.svh"

module branch_predictor import bp_types_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,

	// Lookup from the jump controller
	input  bht_query_t      query,

	// Training from the back end
	input  resolve_bundle_t resolve,

	// One bit per slot, set only for a branch predicted taken
	output slot_mask_t      predict_taken
);

	bp_counter_e bht_q [`BHT_ENTRIES]; // Counter table
	bp_counter_e bht_d [`BHT_ENTRIES]; // Table after this cycle's updates

	logic [`BHT_INDEX_BITS-1:0] upd_index [`RESOLVE_PORTS]; // Entry hit by each port

	////////////////////////////////////////////////////////////
	// Saturating step of one counter
	////////////////////////////////////////////////////////////

	// Correct resolution reinforces the current direction
	// Mispredict pushes one step the other way
	function automatic bp_counter_e step_counter(
		input bp_counter_e cur,
		input logic        mispredict
	);
		logic        toward_taken;
		bp_counter_e nxt;
		toward_taken = cur[1] ^ mispredict;
		nxt          = cur;
		case (cur)
			strong_not_taken: nxt = toward_taken ? weak_not_taken : strong_not_taken;
			weak_not_taken:   nxt = toward_taken ? weak_taken     : strong_not_taken;
			weak_taken:       nxt = toward_taken ? strong_taken   : weak_not_taken;
			strong_taken:     nxt = toward_taken ? strong_taken   : weak_taken; // Saturate
		endcase
		return nxt;
	endfunction

	////////////////////////////////////////////////////////////
	// Read ports
	////////////////////////////////////////////////////////////

	// Old table value, same-cycle updates are not forwarded
	always_comb begin
		for (int s = 0; s < `FETCH_WIDTH; s++) begin
			predict_taken[s] = query.branch[s] & bht_q[query.index[s]][1]; // Trust the flag
		end
	end

	////////////////////////////////////////////////////////////
	// Update ports
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int k = 0; k < `RESOLVE_PORTS; k++) begin
			upd_index[k] = resolve[k].pc[`BHT_INDEX_LSB +: `BHT_INDEX_BITS]; // Same bits as lookup
		end
	end

	// Per entry, apply ports 0..2 in order so a later port sees the earlier step
	always_comb begin
		for (int e = 0; e < `BHT_ENTRIES; e++) begin
			bht_d[e] = bht_q[e]; // Untouched entries hold
			for (int k = 0; k < `RESOLVE_PORTS; k++) begin
				if (resolve[k].valid && (upd_index[k] == e[`BHT_INDEX_BITS-1:0])) begin
					bht_d[e] = step_counter(bht_d[e], resolve[k].mispredict);
				end
			end
		end
	end

	// Counter state, cleared to weakly not taken
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int e = 0; e < `BHT_ENTRIES; e++) begin
				bht_q[e] <= weak_not_taken;
			end
		end else begin
			bht_q <= bht_d;
		end
	end

endmodule

// File: source/jump_controller.sv
`timescale 1ns/1ps
`include "bp_config.svh"

module jump_controller import rv_isa_pkg::*, bp_types_pkg::*; (
	// Raw fetch slots
	input  fetch_bundle_t fetch,

	// Predictor lookup and answer
	output bht_query_t    query,
	input  slot_mask_t    predict_taken,

	// Decisions
	output slot_mask_t    jump, // Taken JAL or predicted-taken branch
	output slot_mask_t    jalr  // JALR, target resolved elsewhere
);

	rv_opcode_e opcode [`FETCH_WIDTH]; // Decoded opcode per slot

	slot_mask_t is_jal;
	slot_mask_t is_jalr;
	slot_mask_t is_branch;

	////////////////////////////////////////////////////////////
	// Per-slot decode
	////////////////////////////////////////////////////////////

	// Only the opcode field matters, upper bits are ignored
	always_comb begin
		for (int s = 0; s < `FETCH_WIDTH; s++) begin
			opcode[s]    = opcode_of(fetch[s].instr);
			is_jal[s]    = (opcode[s] == op_jal);
			is_jalr[s]   = (opcode[s] == op_jalr);
			is_branch[s] = (opcode[s] == op_branch); // Single place the B-type test lives
		end
	end

	////////////////////////////////////////////////////////////
	// Predictor lookup
	////////////////////////////////////////////////////////////

	always_comb begin
		query.branch = is_branch;
		for (int s = 0; s < `FETCH_WIDTH; s++) begin
			query.index[s] = fetch[s].pc[`BHT_INDEX_LSB +: `BHT_INDEX_BITS]; // pc[6:2]
		end
	end

	////////////////////////////////////////////////////////////
	// Decisions
	////////////////////////////////////////////////////////////

	// JAL always jumps
	// Conditional branch jumps on the predictor's say-so
	assign jump = is_jal | (is_branch & predict_taken);

	// Kept apart from jump so the target path can treat it on its own
	assign jalr = is_jalr;

endmodule

// File: source/fetch_jump_unit.sv
`timescale 1ns/1ps

module fetch_jump_unit import bp_types_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,

	// Five fetch slots, combinational path to the flags
	input  fetch_bundle_t   fetch,

	// Branch resolution, sampled at the clock edge
	input  resolve_bundle_t resolve,

	// Per-slot decisions
	output slot_mask_t      jump,
	output slot_mask_t      jalr
);

	bht_query_t query;         // Branch flags and table indices
	slot_mask_t predict_taken; // Table answer per slot

	// Decode and decision
	jump_controller u_jump_controller (
		.fetch         (fetch),
		.query         (query),
		.predict_taken (predict_taken),
		.jump          (jump),
		.jalr          (jalr)
	);

	// Two-bit counter table
	branch_predictor u_branch_predictor (
		.clk           (clk),
		.rst_n         (rst_n),
		.query         (query),
		.resolve       (resolve),
		.predict_taken (predict_taken)
	);

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	localparam int half_period  = 4; // 8 ns clock
	localparam int reset_cycles = 4;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// Release just after an edge, same as the stimulus
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

// File: verification/fetch_jump_unit_chk.sv
`timescale 1ns/1ps
`include "bp_config.svh"

module fetch_jump_unit_chk import rv_isa_pkg::*, bp_types_pkg::*; (
	input logic          clk,
	input logic          rst_n,
	input fetch_bundle_t fetch,
	input slot_mask_t    jump,
	input slot_mask_t    jalr
);

	slot_mask_t slot_jal;    // Raw opcode is JAL
	slot_mask_t slot_jalr;   // Raw opcode is JALR
	slot_mask_t slot_branch; // Raw opcode is a B-type

	// Own decode of the opcode field
	always_comb begin
		for (int s = 0; s < `FETCH_WIDTH; s++) begin
			slot_jal[s]    = (fetch[s].instr[6:0] == op_jal);
			slot_jalr[s]   = (fetch[s].instr[6:0] == op_jalr);
			slot_branch[s] = (fetch[s].instr[6:0] == op_branch);
		end
	end

	////////////////////////////////////////////////////////////
	// Properties
	////////////////////////////////////////////////////////////

	// One kind of flag per slot
	a_no_double_flag: assert property (@(posedge clk) disable iff (!rst_n)
		(jump & jalr) == '0)
		else $error("Slot flagged as jump and jalr together, jump %b jalr %b", jump, jalr);

	// First cycle out of reset
	a_jalr_clear_after_reset: assert property (@(posedge clk)
		($rose(rst_n) && (slot_jalr == '0)) |-> (jalr == '0))
		else $error("Jalr set after reset without a JALR slot, jalr %b", jalr);

	a_jump_source: assert property (@(posedge clk) disable iff (!rst_n)
		(jump & ~(slot_jal | slot_branch)) == '0) // Only JAL or branch may jump
		else $error("Jump on a slot that is not JAL or branch, jump %b", jump);

endmodule

bind fetch_jump_unit fetch_jump_unit_chk u_fetch_jump_unit_chk (
	.clk   (clk),
	.rst_n (rst_n),
	.fetch (fetch),
	.jump  (jump),
	.jalr  (jalr)
);

// File: verification/fetch_jump_unit_tb.sv
`timescale 1ns/1ps
`include "bp_config.svh"

module fetch_jump_unit_tb import bp_types_pkg::*; ();

	localparam int    clk_period = 8;
	localparam string vec_file   = "verification/fetch_jump_input.txt";

	logic            clk;
	logic            rst_n;
	fetch_bundle_t   fetch;
	resolve_bundle_t resolve;
	slot_mask_t      jump;
	slot_mask_t      jalr;

	fetch_bundle_t   vec_fetch   [$]; // One entry per cycle
	resolve_bundle_t vec_resolve [$];
	slot_mask_t      exp_jump    [$];
	slot_mask_t      exp_jalr    [$];

	logic [31:0] rand_state; // LCG state for instruction fill

	tb_clock_gen u_tb_clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	fetch_jump_unit u_fetch_jump_unit (
		.clk     (clk),
		.rst_n   (rst_n),
		.fetch   (fetch),
		.resolve (resolve),
		.jump    (jump),
		.jalr    (jalr)
	);

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic stop_on_failure(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "Run stopped after a failure");
	endtask

	task automatic check_jump(input slot_mask_t got, input slot_mask_t exp, input int vec);
		if (got !== exp) begin
			stop_on_failure($sformatf("** Error at %0d ns: jump mask %b, expected %b in vector %0d",
				$time, got, exp, vec));
		end
	endtask

	task automatic check_jalr(input slot_mask_t got, input slot_mask_t exp, input int vec);
		if (got !== exp) begin
			stop_on_failure($sformatf("** Error at %0d ns: jalr mask %b, expected %b in vector %0d",
				$time, got, exp, vec));
		end
	endtask

	// One vector per cycle and line
	// Lines starting with # are comments
	task automatic load_vectors();
		int              fd;
		int              cnt;
		int              line_no;
		string           line;
		logic [31:0]     field [21];
		fetch_bundle_t   fb;
		resolve_bundle_t rb;
		line_no = 0;
		fd      = $fopen(vec_file, "r");
		if (fd == 0) begin
			stop_on_failure({"Cannot open the vector file ", vec_file});
		end else begin
			while ($fgets(line, fd) != 0) begin
				line_no++;
				if (line.len() < 2 || line.getc(0) == "#") begin
					continue; // Blank or comment
				end
				cnt = $sscanf(line,
					"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					field[0], field[1], field[2], field[3], field[4], field[5], field[6],
					field[7], field[8], field[9], field[10], field[11], field[12], field[13],
					field[14], field[15], field[16], field[17], field[18], field[19], field[20]);
				if (cnt != 21) begin
					stop_on_failure($sformatf("Vector line %0d of %s has %0d fields instead of 21",
						line_no, vec_file, cnt));
				end else begin
					for (int s = 0; s < `FETCH_WIDTH; s++) begin
						rand_state  = lcg_next(rand_state);
						fb[s].pc    = field[2*s];
						fb[s].instr = {rand_state[31:7], field[2*s+1][6:0]}; // Random above opcode
					end
					for (int k = 0; k < `RESOLVE_PORTS; k++) begin
						rb[k].valid      = field[10+3*k][0];
						rb[k].mispredict = field[11+3*k][0];
						rb[k].pc         = field[12+3*k];
					end
					vec_fetch.push_back(fb);
					vec_resolve.push_back(rb);
					exp_jump.push_back(field[19][`FETCH_WIDTH-1:0]);
					exp_jalr.push_back(field[20][`FETCH_WIDTH-1:0]);
				end
			end
			$fclose(fd);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		fetch      = '0;
		resolve    = '0;
		rand_state = 32'd96363;
		load_vectors();
		if (vec_fetch.size() == 0) begin
			stop_on_failure("The vector file holds no vectors");
		end

		// Watchdog
		fork
			begin
				#((vec_fetch.size() + 20) * clk_period);
				stop_on_failure("Watchdog expired before all vectors were applied");
			end
		join_none

		wait (rst_n === 1'b1);
		for (int i = 0; i < vec_fetch.size(); i++) begin
			@(posedge clk);
			#1;
			fetch   = vec_fetch[i];
			resolve = vec_resolve[i]; // Takes effect at the next edge
			#(clk_period - 2);        // Just before the next edge
			check_jump(jump, exp_jump[i], i);
			check_jalr(jalr, exp_jalr[i], i);
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: verification/fetch_jump_input.txt
# pc op for slots 0..4 | valid mispredict pc for resolve ports 0..2 | jump jalr
# All hex, op is the 7-bit opcode field, masks hold slot 0 in bit 0
100 6f 104 67 108 13 10c 03 110 23  0 0 000 0 0 000 0 0 000  01 02
100 37 104 17 108 33 10c 73 110 67  0 0 000 0 0 000 0 0 000  00 10
100 6f 104 6f 108 6f 10c 6f 110 6f  0 0 000 0 0 000 0 0 000  1f 00
100 0f 104 73 108 67 10c 33 110 6f  0 0 000 0 0 000 0 0 000  10 04
010 63 020 63 030 63 040 63 050 63  1 1 010 1 0 020 0 0 000  00 00
010 63 020 63 030 63 040 63 050 63  1 1 020 0 0 000 0 0 000  01 00
010 63 020 63 030 63 040 63 050 63  1 1 020 0 0 000 0 0 000  01 00
010 63 020 63 030 63 040 63 050 63  1 0 010 0 0 000 0 0 000  03 00
010 63 020 63 030 63 040 63 050 63  1 0 010 1 0 010 1 0 010  03 00
010 63 020 63 030 63 040 63 050 63  1 1 010 0 0 000 0 0 000  03 00
010 63 020 63 030 63 040 63 050 63  1 1 010 0 0 000 0 0 000  03 00
010 63 020 63 030 63 040 63 050 63  1 0 030 1 1 030 1 1 030  02 00
010 63 020 63 030 63 040 63 050 63  0 1 030 0 1 010 0 0 020  06 00
010 63 020 63 030 63 040 63 050 63  1 1 030 1 0 030 1 1 030  06 00
010 63 020 63 030 63 040 63 050 63  1 1 040 1 1 040 1 1 040  02 00
040 63 0c0 63 1c0 63 050 63 010 63  0 0 000 0 0 000 0 0 000  07 00
0c0 63 200 6f 204 67 050 63 040 63  1 1 0c0 0 0 000 0 0 000  13 04
0c0 63 200 6f 204 67 050 63 040 63  0 0 000 0 0 000 0 0 000  02 04
020 63 030 63 010 63 050 63 080 63  0 0 000 0 0 000 0 0 000  01 00
100 13 104 13 108 13 10c 13 110 13  0 0 000 0 0 000 0 0 000  00 00
300 67 304 6f 020 63 30c 33 310 23  0 0 000 0 0 000 0 0 000  06 01

// File: all.f
+incdir+source
source/rv_isa_pkg.sv
source/bp_types_pkg.sv
source/branch_predictor.sv
source/jump_controller.sv
source/fetch_jump_unit.sv
verification/tb_clock_gen.sv
verification/fetch_jump_unit_chk.sv
verification/fetch_jump_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the fetch jump unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f all.f --top-module fetch_jump_unit_tb -o fetch_jump_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit $build_status
fi

./obj_dir/fetch_jump_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "Simulation ended with status $sim_status"
	exit $sim_status
fi

echo "Simulation ended with status 0"
exit 0
